// ==== conv_pkg.sv ====
package conv_pkg;

    ////////////////////
    // array sizes
    ////////////////////
    localparam int ROW_NUM  = 3;    // output rows in parallel
    localparam int CHAN_NUM = 4;    // output channels in parallel

    localparam int PIXEL_WIDTH  = 8;
    localparam int WEIGHT_WIDTH = 8;
    localparam int MUL_WIDTH    = PIXEL_WIDTH + WEIGHT_WIDTH;
    localparam int HEADROOM     = 8;                    // guard bits for accumulation
    localparam int ACC_WIDTH    = 16 + HEADROOM;
    localparam int LEN_WIDTH    = 16;

    ////////////////////
    // requantization
    ////////////////////
    localparam int BIAS_WIDTH  = 8;
    localparam int TAIL_WIDTH  = 16;                    // unsigned scale tail
    localparam int RANK_WIDTH  = 5;
    localparam int SUM_WIDTH   = ACC_WIDTH + 1;         // sum plus bias
    localparam int PROD_WIDTH  = 43;
    localparam int QUANT_WIDTH = 8;
    localparam int QUANT_MAX   = 2 ** (QUANT_WIDTH - 1) - 1;
    localparam int QUANT_MIN   = -(2 ** (QUANT_WIDTH - 1));

    localparam int CHAN_IDX_WIDTH = $clog2(CHAN_NUM);

    ////////////////////
    // shared types
    ////////////////////
    typedef logic [ROW_NUM-1:0][PIXEL_WIDTH-1:0]   pixel_vec_t;   // one pixel per row
    typedef logic [CHAN_NUM-1:0][WEIGHT_WIDTH-1:0] weight_vec_t;  // one weight per channel

    typedef struct packed {
        pixel_vec_t  pixels;
        weight_vec_t weights;
    } in_beat_t;

    typedef struct packed {
        in_beat_t beat;
        logic     first;    // count 0 of the group
        logic     last;     // count acc_len - 1
    } feed_beat_t;

    typedef logic [ROW_NUM-1:0][ACC_WIDTH-1:0] acc_row_t;
    typedef acc_row_t [CHAN_NUM-1:0]           acc_tile_t;

    typedef struct packed {
        logic signed [BIAS_WIDTH-1:0] bias;
        logic [TAIL_WIDTH-1:0]        tail;
        logic [RANK_WIDTH-1:0]        rank;
    } quant_cfg_t;

    typedef quant_cfg_t [CHAN_NUM-1:0] quant_cfg_vec_t;

    typedef struct packed {
        logic [CHAN_IDX_WIDTH-1:0]            chan;
        logic [ROW_NUM-1:0][QUANT_WIDTH-1:0]  quant;
    } out_beat_t;

    typedef enum logic {
        DRAIN_IDLE,
        DRAIN_RUN
    } drain_state_e;

endpackage

// ==== conv_feeder.sv ====
module conv_feeder import conv_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  in_beat_t             in_beat,
    input  logic [LEN_WIDTH-1:0] acc_len,
    output logic                 feed_valid,
    output feed_beat_t           feed_beat
);

    logic [LEN_WIDTH-1:0] beat_cnt;     // position inside the current group
    logic                 first_beat;
    logic                 last_beat;

    assign first_beat = (beat_cnt == '0);
    assign last_beat  = (beat_cnt == LEN_WIDTH'(acc_len - 1'b1));

    ////////////////////
    // beat counter
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            feed_valid <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            feed_valid <= in_valid;
            if (in_valid) begin
                if (last_beat) begin
                    beat_cnt <= '0;     // wrap for next group
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // operand register, flags ride along with the beat
    always_ff @(posedge clk) begin
        if (in_valid) begin
            feed_beat.beat  <= in_beat;
            feed_beat.first <= first_beat;
            feed_beat.last  <= last_beat;
        end
    end

    // shorter groups would let a tile overrun the drain
    a_acc_len_min : assert property (
        @(posedge clk) disable iff (reset)
        in_valid |-> (acc_len >= CHAN_NUM)
    ) else $error("acc_len below CHAN_NUM while beats are sent");

endmodule

// ==== mac_array.sv ====
module mac_array import conv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       feed_valid,
    input  feed_beat_t feed_beat,
    output logic       tile_done,
    output acc_tile_t  tile
);

    acc_tile_t acc;         // running sums, [chan][row]
    acc_tile_t acc_next;

    ////////////////////
    // mac cells
    ////////////////////
    always_comb begin
        logic signed [MUL_WIDTH-1:0] prod;
        for (int c = 0; c < CHAN_NUM; c++) begin
            for (int r = 0; r < ROW_NUM; r++) begin
                prod = $signed(feed_beat.beat.pixels[r]) *
                       $signed(feed_beat.beat.weights[c]);
                if (feed_beat.first) begin
                    acc_next[c][r] = ACC_WIDTH'(prod);      // restart the group
                end else begin
                    acc_next[c][r] = $signed(acc[c][r]) + prod;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tile_done <= 1'b0;
        end else begin
            tile_done <= feed_valid && feed_beat.last;
        end
    end

    // snapshot on the last beat frees acc for the next group
    always_ff @(posedge clk) begin
        if (feed_valid) begin
            acc <= acc_next;
            if (feed_beat.last) begin
                tile <= acc_next;
            end
        end
    end

    a_tile_done_pulse : assert property (
        @(posedge clk) disable iff (reset)
        tile_done |=> !tile_done
    ) else $error("tile_done stayed high for more than one cycle");

endmodule

// ==== requant_unit.sv ====
module requant_unit import conv_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      q_valid,
    input  acc_row_t                  q_sums,
    input  quant_cfg_t                q_cfg,
    input  logic [CHAN_IDX_WIDTH-1:0] q_chan,
    output logic                      res_valid,
    output out_beat_t                 res
);

    logic                               s1_valid;
    logic [ROW_NUM-1:0][PROD_WIDTH-1:0] s1_prod;
    logic [RANK_WIDTH-1:0]              s1_rank;
    logic [CHAN_IDX_WIDTH-1:0]          s1_chan;
    logic [ROW_NUM-1:0][PROD_WIDTH-1:0] prod_next;
    out_beat_t                          res_next;

    ////////////////////
    // stage 1: bias and tail
    ////////////////////
    always_comb begin
        logic signed [SUM_WIDTH-1:0]  biased;
        logic signed [PROD_WIDTH-1:0] scaled;
        for (int r = 0; r < ROW_NUM; r++) begin
            biased       = $signed(q_sums[r]) + q_cfg.bias;
            scaled       = biased * $signed({1'b0, q_cfg.tail});  // tail is unsigned
            prod_next[r] = scaled;
        end
    end

    ////////////////////
    // stage 2: round, shift, clip
    ////////////////////
    always_comb begin
        logic signed [PROD_WIDTH-1:0] rounded;
        logic signed [PROD_WIDTH-1:0] shifted;
        res_next.chan = s1_chan;
        for (int r = 0; r < ROW_NUM; r++) begin
            rounded = $signed(s1_prod[r]);
            if (s1_rank != '0) begin
                rounded = rounded + (PROD_WIDTH'(1) << (s1_rank - 1'b1));  // half lsb
            end
            shifted = rounded >>> s1_rank;
            if (shifted > QUANT_MAX) begin
                res_next.quant[r] = QUANT_WIDTH'(QUANT_MAX);
            end else if (shifted < QUANT_MIN) begin
                res_next.quant[r] = QUANT_WIDTH'(QUANT_MIN);
            end else begin
                res_next.quant[r] = shifted[QUANT_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= q_valid;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_prod <= prod_next;
        s1_rank <= q_cfg.rank;
        s1_chan <= q_chan;
        res     <= res_next;
    end

endmodule

// ==== conv_drain.sv ====
module conv_drain import conv_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           tile_done,
    input  acc_tile_t      tile,
    input  quant_cfg_vec_t quant_cfg,
    output logic           out_valid,
    output out_beat_t      out_beat
);

    drain_state_e              state;
    logic [CHAN_IDX_WIDTH-1:0] chan;        // channel to issue, wraps back to 0 when idle
    acc_tile_t                 tile_reg;
    acc_tile_t                 issue_src;
    logic                      q_valid;
    acc_row_t                  q_sums;
    quant_cfg_t                q_cfg;
    logic [CHAN_IDX_WIDTH-1:0] q_chan;
    logic                      res_valid;
    out_beat_t                 res;

    // channel 0 goes out straight from the array snapshot
    assign issue_src  = (state == DRAIN_IDLE) ? tile : tile_reg;

    ////////////////////
    // channel walk FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= DRAIN_IDLE;
            chan    <= '0;
            q_valid <= 1'b0;
        end else begin
            q_valid <= 1'b0;
            case (state)
                DRAIN_IDLE: begin
                    if (tile_done) begin
                        state   <= DRAIN_RUN;
                        chan    <= CHAN_IDX_WIDTH'(1);
                        q_valid <= 1'b1;
                    end
                end
                DRAIN_RUN: begin
                    q_valid <= 1'b1;
                    chan    <= chan + 1'b1;
                    if (chan == CHAN_IDX_WIDTH'(CHAN_NUM - 1)) begin
                        state <= DRAIN_IDLE;    // last channel issued
                    end
                end
                default: state <= DRAIN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DRAIN_IDLE && tile_done) begin
            tile_reg <= tile;
        end
        q_sums <= issue_src[chan];
        q_cfg  <= quant_cfg[chan];
        q_chan <= chan;
    end

    requant_unit requant_unit_i (
        .clk       (clk),
        .reset     (reset),
        .q_valid   (q_valid),
        .q_sums    (q_sums),
        .q_cfg     (q_cfg),
        .q_chan    (q_chan),
        .res_valid (res_valid),
        .res       (res)
    );

    // output register
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_beat <= res;
    end

    a_no_overlap : assert property (
        @(posedge clk) disable iff (reset)
        tile_done |-> (state == DRAIN_IDLE)
    ) else $error("tile_done arrived while the drain was still walking channels");

endmodule

// ==== conv_datapath.sv ====
module conv_datapath import conv_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  in_beat_t             in_beat,
    input  logic [LEN_WIDTH-1:0] acc_len,
    input  quant_cfg_vec_t       quant_cfg,
    output logic                 out_valid,
    output out_beat_t            out_beat
);

    logic       feed_valid;
    feed_beat_t feed_beat;
    logic       tile_done;
    acc_tile_t  tile;

    conv_feeder conv_feeder_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .acc_len    (acc_len),
        .feed_valid (feed_valid),
        .feed_beat  (feed_beat)
    );

    mac_array mac_array_i (
        .clk        (clk),
        .reset      (reset),
        .feed_valid (feed_valid),
        .feed_beat  (feed_beat),
        .tile_done  (tile_done),
        .tile       (tile)
    );

    // walks channels of a finished tile
    conv_drain conv_drain_i (
        .clk       (clk),
        .reset     (reset),
        .tile_done (tile_done),
        .tile      (tile),
        .quant_cfg (quant_cfg),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

endmodule

// ==== tb_conv_datapath.sv ====
module tb_conv_datapath import conv_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int  CLK_PERIOD   = 4;
    localparam real DRIVE_DELAY  = 0.5;
    localparam int  RESET_CYCLES = 8;
    localparam int  IDLE_CYCLES  = 20;
    localparam int  SINGLE_LEN   = 9;
    localparam int  B2B_GROUPS   = 6;
    localparam int  GAP_GROUPS   = 3;
    localparam int  GAP_MAX      = 3;
    localparam int  EXT_GROUPS   = 8;
    localparam int  MARGIN       = 100;     // drain time of every test
    localparam int  RUN_CYCLES   = RESET_CYCLES + IDLE_CYCLES + SINGLE_LEN
                                 + B2B_GROUPS * CHAN_NUM + EXT_GROUPS * CHAN_NUM
                                 + GAP_GROUPS * SINGLE_LEN * (GAP_MAX + 1);

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 in_valid;
    in_beat_t             in_beat;
    logic [LEN_WIDTH-1:0] acc_len;
    quant_cfg_vec_t       quant_cfg;
    logic                 out_valid;
    out_beat_t            out_beat;

    int        errors   = 0;
    int        pending  = 0;    // results still owed by the DUT
    int        cyc      = 0;
    int        beat_idx = 0;    // model position inside the group
    int        acc_model [CHAN_NUM][ROW_NUM];
    out_beat_t exp_q [$];
    string     name_q [$];
    int        lat_q [$];       // cycle of the first result per group
    string     test_name = "reset_idle";

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    conv_datapath conv_datapath_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .acc_len   (acc_len),
        .quant_cfg (quant_cfg),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

    ////////////////////
    // reference model
    ////////////////////
    function automatic logic [QUANT_WIDTH-1:0] requant(input int sum, input quant_cfg_t cfg);
        longint val;
        val = (longint'(sum) + longint'($signed(cfg.bias))) * longint'(cfg.tail);
        if (cfg.rank != 0) val += longint'(1) << (cfg.rank - 1);   // round half up
        val = val >>> cfg.rank;
        if (val > 127) return 8'h7f;
        if (val < -128) return 8'h80;
        return val[7:0];
    endfunction

    task automatic queue_group();
        out_beat_t want;
        lat_q.push_back(cyc + 6);   // sampled next edge, out_valid 5 edges later
        for (int c = 0; c < CHAN_NUM; c++) begin
            want.chan = CHAN_IDX_WIDTH'(c);
            for (int r = 0; r < ROW_NUM; r++) begin
                want.quant[r] = requant(acc_model[c][r], quant_cfg[c]);
            end
            exp_q.push_back(want);
            name_q.push_back(test_name);
            pending++;
        end
    endtask

    ////////////////////
    // stimulus helpers
    ////////////////////
    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic idle(input int cycles);
        in_valid = 1'b0;
        repeat (cycles) step();
    endtask

    task automatic wait_drained();
        in_valid = 1'b0;
        while (pending != 0) step();    // watchdog catches a stall
    endtask

    task automatic send_beat(input in_beat_t beat);
        in_valid = 1'b1;
        in_beat  = beat;
        for (int c = 0; c < CHAN_NUM; c++) begin
            for (int r = 0; r < ROW_NUM; r++) begin
                acc_model[c][r] = (beat_idx == 0 ? 0 : acc_model[c][r])
                                + $signed(beat.pixels[r]) * $signed(beat.weights[c]);
            end
        end
        if (beat_idx == int'(acc_len) - 1) begin
            queue_group();
            beat_idx = 0;
        end else begin
            beat_idx++;
        end
        step();
    endtask

    function automatic in_beat_t random_beat();
        in_beat_t b;
        for (int r = 0; r < ROW_NUM; r++) b.pixels[r] = PIXEL_WIDTH'($urandom());
        for (int c = 0; c < CHAN_NUM; c++) b.weights[c] = WEIGHT_WIDTH'($urandom());
        return b;
    endfunction

    // fixed sign patterns first, then random corners
    function automatic in_beat_t extreme_beat(input int g);
        in_beat_t   b;
        logic [7:0] corner [4] = '{8'h7f, 8'h80, 8'h01, 8'hff};
        for (int r = 0; r < ROW_NUM; r++) begin
            b.pixels[r] = (g >= 4) ? corner[$urandom_range(3, 0)] : corner[g & 1];
        end
        for (int c = 0; c < CHAN_NUM; c++) begin
            b.weights[c] = (g >= 4) ? corner[$urandom_range(3, 0)] : corner[(g >> 1) & 1];
        end
        return b;
    endfunction

    task automatic random_cfg();
        for (int c = 0; c < CHAN_NUM; c++) begin
            quant_cfg[c].bias = BIAS_WIDTH'($urandom());
            quant_cfg[c].tail = TAIL_WIDTH'($urandom());
            quant_cfg[c].rank = RANK_WIDTH'($urandom_range(24, 12));   // mix of clip and pass
        end
    endtask

    ////////////////////
    // checks
    ////////////////////
    a_no_early_output : assert property (@(posedge clk) disable iff (reset)
        out_valid |-> pending > 0
    ) else begin
        $display("out_valid came while no result was expected");
        errors++;
    end

    a_chan_order : assert property (@(posedge clk) disable iff (reset)
        out_valid && out_beat.chan != CHAN_NUM - 1 |=>
            out_valid && out_beat.chan == $past(out_beat.chan) + 1
    ) else begin
        $display("channel burst broke off or skipped a channel");
        errors++;
    end

    a_burst_start : assert property (@(posedge clk) disable iff (reset)
        $rose(out_valid) |-> out_beat.chan == 0
    ) else begin
        $display("result burst did not start at channel 0");
        errors++;
    end

    always @(posedge clk) begin
        out_beat_t want;
        string     name;
        if (!reset && out_valid && pending > 0) begin
            want = exp_q.pop_front();
            name = name_q.pop_front();
            pending--;
            assert (out_beat === want) else begin
                $display("[ERROR] %s: expected %h, actual %h", name, want, out_beat);
                errors++;
            end
            if (want.chan == 0) begin
                assert (cyc == lat_q[0]) else begin
                    $display("[ERROR] %s latency: expected cycle %0d, actual %0d",
                             name, lat_q[0], cyc);
                    errors++;
                end
                void'(lat_q.pop_front());
            end
        end
    end

    initial begin
        #((RUN_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog expired with %0d results still outstanding", pending);
        $display("tests failed");
        $finish;
    end

    ////////////////////
    // test sequence
    ////////////////////
    initial begin
        void'($urandom(38313));
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_beat   = '0;
        acc_len   = LEN_WIDTH'(SINGLE_LEN);
        quant_cfg = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        idle(IDLE_CYCLES);      // nothing may come out yet

        test_name = "single_group";
        random_cfg();
        repeat (SINGLE_LEN) send_beat(random_beat());
        wait_drained();

        test_name = "back_to_back";     // two tiles in flight
        acc_len   = LEN_WIDTH'(CHAN_NUM);
        random_cfg();
        repeat (B2B_GROUPS * CHAN_NUM) send_beat(random_beat());
        wait_drained();

        test_name = "input_gaps";
        acc_len   = LEN_WIDTH'(SINGLE_LEN);
        random_cfg();
        repeat (GAP_GROUPS * SINGLE_LEN) begin
            send_beat(random_beat());
            idle($urandom_range(GAP_MAX, 0));
        end
        wait_drained();

        test_name    = "extremes";
        acc_len      = LEN_WIDTH'(CHAN_NUM);
        quant_cfg[0] = '{bias: 8'h7f, tail: 16'hffff, rank: 5'd0};
        quant_cfg[1] = '{bias: 8'h80, tail: 16'hffff, rank: 5'd0};
        quant_cfg[2] = '{bias: 8'h7f, tail: 16'hffff, rank: 5'd31};
        quant_cfg[3] = '{bias: 8'h80, tail: 16'hffff, rank: 5'd31};
        for (int g = 0; g < EXT_GROUPS; g++) begin
            repeat (CHAN_NUM) send_beat(extreme_beat(g));
        end
        wait_drained();

        idle(2);
        $display("summary: %0d errors", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
conv_pkg.sv
conv_feeder.sv
mac_array.sv
requant_unit.sv
conv_drain.sv
conv_datapath.sv
tb_conv_datapath.sv

// ==== Bender.yml ====
package:
  name: conv_datapath

sources:
  - conv_pkg.sv
  - conv_feeder.sv
  - mac_array.sv
  - requant_unit.sv
  - conv_drain.sv
  - conv_datapath.sv
  - target: test
    files:
      - tb_conv_datapath.sv
